// File: Bender.yml
package:
  name: banked_memory

export_include_dirs:
  - .

sources:
  - mem_pkg.sv
  - bank_router.sv
  - mem_bank.sv
  - read_merge.sv
  - banked_memory.sv
  - target: test
    files:
      - tb_banked_memory.sv

// File: bank_router.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module bank_router (
   input  wire logic           clk,
   input  wire logic           rst,
   input  wire mem_pkg::mem_req_t req,
   output mem_pkg::bank_req_t  bank_req [`MEM_NUM_BANKS],
   output logic                misalign
);

   import mem_pkg::*;

   //////////////////////////////////////////////////
   // Request decode
   //////////////////////////////////////////////////

   logic                       req_present;
   logic                       req_aligned;
   logic [`MEM_BANK_SEL_W-1:0] bank_sel;
   logic [`MEM_INDEX_W-1:0]    word_index;
   logic [`MEM_NUM_BANKS-1:0]  bank_active;

   // Anything but idle is a request
   assign req_present = (req.op != OP_IDLE);
   // Word access only so bit 0 must be clear
   assign req_aligned = ~req.addr[0];

   // Low word bits pick the bank so that neighbors interleave
   assign bank_sel   = req.addr[`MEM_BANK_SEL_W:1];
   // Remaining upper bits address the word inside the bank
   assign word_index = req.addr[`MEM_ADDR_W-1:`MEM_BANK_SEL_W+1];

   //////////////////////////////////////////////////
   // Registered bank ports
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
            bank_req[b] <= '{op: OP_IDLE, default: '0};
         end
         misalign <= 1'b0;
      end else begin
         // One cycle pulse while the request itself is dropped
         misalign <= req_present & ~req_aligned;
         for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
            if (req_present && req_aligned && bank_sel == `MEM_BANK_SEL_W'(b)) begin
               bank_req[b] <= '{op: req.op, index: word_index, wdata: req.wdata};
            end else begin
               // Every other bank sees an idle cycle
               bank_req[b] <= '{op: OP_IDLE, default: '0};
            end
         end
      end
   end

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   // Active flag per bank
   always_comb begin
      for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
         bank_active[b] = (bank_req[b].op != OP_IDLE);
      end
   end

   // Single request port so never more than one bank busy
   a_one_bank: assert property (@(posedge clk) disable iff (rst)
      $onehot0(bank_active));

endmodule

`default_nettype wire

// File: banked_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module banked_memory (
   input  wire logic          clk,
   input  wire logic          rst,
   input  wire mem_pkg::mem_req_t req,
   output mem_pkg::mem_rsp_t  rsp,
   output logic               misalign
);

   import mem_pkg::*;

   //////////////////////////////////////////////////
   // Internal buses
   //////////////////////////////////////////////////

   // Router to banks, one entry per bank
   wire bank_req_t bank_req [`MEM_NUM_BANKS];
   // Banks to merge
   wire mem_rsp_t  bank_rsp [`MEM_NUM_BANKS];

   //////////////////////////////////////////////////
   // Request side
   //////////////////////////////////////////////////

   // Alignment check and bank decode, one cycle
   bank_router router_i (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .bank_req (bank_req),
      .misalign (misalign)
   );

   //////////////////////////////////////////////////
   // Banks
   //////////////////////////////////////////////////

   // Identical banks, consecutive words land in
   // consecutive banks
   for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
      mem_bank bank_i (
         .clk      (clk),
         .rst      (rst),
         .bank_req (bank_req[b]),
         .bank_rsp (bank_rsp[b])
      );
   end

   //////////////////////////////////////////////////
   // Response side
   //////////////////////////////////////////////////

   // Collects the single bank answer, one more cycle
   read_merge merge_i (
      .clk      (clk),
      .rst      (rst),
      .bank_rsp (bank_rsp),
      .rsp      (rsp)
   );

   // Every response traces back to a read on the port.
   // Router, bank pipeline and merge register add up to 6 cycles
   a_total_lat: assert property (@(posedge clk) disable iff (rst)
      rsp.valid |-> $past(req.op == OP_READ && !req.addr[0], `MEM_BANK_LAT + 2));

endmodule

`default_nettype wire

// File: mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module mem_bank (
   input  wire logic            clk,
   input  wire logic            rst,
   input  wire mem_pkg::bank_req_t bank_req,
   output mem_pkg::mem_rsp_t    bank_rsp
);

   import mem_pkg::*;

   //////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////

   // One word per index with contents undefined until written
   logic [`MEM_DATA_W-1:0] mem_q [2**`MEM_INDEX_W];

   // Read pipeline where stage 0 is filled on the sampling edge
   mem_rsp_t stage_q [`MEM_BANK_LAT];

   // Single cycle write
   always_ff @(posedge clk) begin
      if (bank_req.op == OP_WRITE) begin
         mem_q[bank_req.index] <= bank_req.wdata;
      end
   end

   //////////////////////////////////////////////////
   // Read pipeline
   //////////////////////////////////////////////////

   // Each stage holds its own read so one read can
   // enter every cycle while older ones move on
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int s = 0; s < `MEM_BANK_LAT; s++) begin
            stage_q[s] <= '0;
         end
      end else begin
         // Capture the addressed word
         if (bank_req.op == OP_READ) begin
            stage_q[0] <= '{valid: 1'b1, rdata: mem_q[bank_req.index]};
         end else begin
            // Bubble with data kept at zero
            stage_q[0] <= '0;
         end
         // Shift toward the output
         for (int s = 1; s < `MEM_BANK_LAT; s++) begin
            stage_q[s] <= stage_q[s-1];
         end
      end
   end

   // Last stage is the bank response
   assign bank_rsp = stage_q[`MEM_BANK_LAT-1];

   //////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////

   // Response exactly MEM_BANK_LAT cycles after the read
   // and never without one
   a_read_lat: assert property (@(posedge clk) disable iff (rst)
      bank_rsp.valid == $past(bank_req.op == OP_READ, `MEM_BANK_LAT));

endmodule

`default_nettype wire

// File: mem_defs.svh
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

// Byte address on the request port
`define MEM_ADDR_W 16
// One data word
`define MEM_DATA_W 16

//////////////////////////////////////////////////
// Bank organization
//////////////////////////////////////////////////

// Word interleaved over four banks
`define MEM_NUM_BANKS 4
// Bank select, address bits 2:1
`define MEM_BANK_SEL_W 2
// Word index inside one bank, address bits 15:3
`define MEM_INDEX_W 13

// Read pipeline depth of one bank, sampling edge counts as stage one
`define MEM_BANK_LAT 4

`endif

// File: mem_pkg.sv
`default_nettype none

`include "mem_defs.svh"

package mem_pkg;

   // Request opcode, idle means no request this cycle
   typedef enum logic [1:0] {
      OP_IDLE  = 2'd0,
      OP_READ  = 2'd1,
      OP_WRITE = 2'd2
   } mem_op_e;

   // External request, byte address
   typedef struct packed {
      mem_op_e                op;
      logic [`MEM_ADDR_W-1:0] addr;
      logic [`MEM_DATA_W-1:0] wdata;
   } mem_req_t;

   // Request after bank decode, word index only
   typedef struct packed {
      mem_op_e                 op;
      logic [`MEM_INDEX_W-1:0] index;
      logic [`MEM_DATA_W-1:0]  wdata;
   } bank_req_t;

   // Read response, shared by banks and top level
   typedef struct packed {
      logic                   valid;
      logic [`MEM_DATA_W-1:0] rdata;
   } mem_rsp_t;

endpackage

`default_nettype wire

// File: read_merge.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module read_merge (
   input  wire logic          clk,
   input  wire logic          rst,
   input  wire mem_pkg::mem_rsp_t bank_rsp [`MEM_NUM_BANKS],
   output mem_pkg::mem_rsp_t  rsp
);

   import mem_pkg::*;

   //////////////////////////////////////////////////
   // Response select
   //////////////////////////////////////////////////

   logic [`MEM_NUM_BANKS-1:0] valid_vec;
   mem_rsp_t                  merge_d;

   // At most one bank answers per cycle so a plain
   // priority pick is enough
   always_comb begin
      merge_d = '0;
      for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
         valid_vec[b] = bank_rsp[b].valid;
         if (bank_rsp[b].valid) begin
            merge_d.rdata = bank_rsp[b].rdata;
         end
      end
      // Any bank valid
      merge_d.valid = |valid_vec;
   end

   //////////////////////////////////////////////////
   // Output register
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         rsp <= '0;
      end else begin
         rsp <= merge_d;
      end
   end

   // Two banks answering together would mean lost data
   a_one_rsp: assert property (@(posedge clk) disable iff (rst)
      $onehot0(valid_vec));

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
mem_pkg.sv
bank_router.sv
mem_bank.sv
read_merge.sv
banked_memory.sv
tb_banked_memory.sv

// File: tb_banked_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_defs.svh"

module tb_banked_memory;

   import mem_pkg::*;

   //////////////////////////////////////////////////
   // Clock, reset and DUT
   //////////////////////////////////////////////////

   // Directed tests take a few hundred cycles, random traffic included
   localparam int TIMEOUT_CYCLES = 2000;
   // Request to response, router + bank + merge
   localparam int READ_LAT = 6;

   logic     clk;
   logic     rst;
   mem_req_t req;
   mem_rsp_t rsp;
   logic     misalign;

   // Edges seen so far, also drives the timeout
   int       cycle_cnt = 0;
   logic     checking = 1'b0;
   int       rsp_errors = 0;
   int       misalign_errors = 0;

   banked_memory dut_i (
      .clk      (clk),
      .rst      (rst),
      .req      (req),
      .rsp      (rsp),
      .misalign (misalign)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   //////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////

   // One word per aligned byte address, index is addr[15:1]
   logic [`MEM_DATA_W-1:0] model_mem [0:32767];
   bit                     model_known [0:32767];

   // Expected reads in issue order, due cycle and word
   int                     rd_due_q [$];
   logic [`MEM_DATA_W-1:0] rd_data_q [$];
   // Cycles where misalign must be high
   int                     ma_due_q [$];

   //////////////////////////////////////////////////
   // Compare tasks
   //////////////////////////////////////////////////

   task automatic check_rsp(input mem_rsp_t got, input mem_rsp_t exp, input string what);
      // Data only matters when a response is expected
      if (got.valid !== exp.valid || (exp.valid && got.rdata !== exp.rdata)) begin
         rsp_errors++;
         $display("FAIL t=%0t %s: got valid=%b rdata=%h, expected valid=%b rdata=%h",
                  $time, what, got.valid, got.rdata, exp.valid, exp.rdata);
      end
   endtask

   task automatic check_misalign(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         misalign_errors++;
         $display("FAIL t=%0t %s: got misalign=%b, expected %b", $time, what, got, exp);
      end
   endtask

   // Output monitor, sampled on the edge so values are those of the past cycle
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (checking) begin
         if (rd_due_q.size() != 0 && rd_due_q[0] == cycle_cnt) begin
            check_rsp(rsp, mem_rsp_t'{valid: 1'b1, rdata: rd_data_q[0]}, "read response");
            void'(rd_due_q.pop_front());
            void'(rd_data_q.pop_front());
         end else begin
            check_rsp(rsp, mem_rsp_t'{valid: 1'b0, rdata: '0}, "no response due");
         end
         if (ma_due_q.size() != 0 && ma_due_q[0] == cycle_cnt) begin
            check_misalign(misalign, 1'b1, "misalign pulse");
            void'(ma_due_q.pop_front());
         end else begin
            check_misalign(misalign, 1'b0, "misalign idle");
         end
      end
   end

   //////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////

   task automatic drive_idle();
      @(posedge clk);
      req <= mem_req_t'{op: OP_IDLE, default: '0};
   endtask

   task automatic issue_write(input logic [15:0] addr, input logic [15:0] data);
      @(posedge clk);
      req <= mem_req_t'{op: OP_WRITE, addr: addr, wdata: data};
      // Sampled next edge, pulse visible one edge later
      if (addr[0]) begin
         ma_due_q.push_back(cycle_cnt + 2);
      end else begin
         model_mem[addr[15:1]] = data;
         model_known[addr[15:1]] = 1'b1;
      end
   endtask

   task automatic issue_read(input logic [15:0] addr);
      @(posedge clk);
      req <= mem_req_t'{op: OP_READ, addr: addr, wdata: '0};
      if (addr[0]) begin
         ma_due_q.push_back(cycle_cnt + 2);
      end else begin
         // Issue is the sampling edge, one after this one
         rd_due_q.push_back(cycle_cnt + 1 + READ_LAT);
         rd_data_q.push_back(model_mem[addr[15:1]]);
      end
   endtask

   // Idle until every expected event has been seen, plus a margin
   task automatic drain_responses();
      drive_idle();
      while (rd_due_q.size() != 0 || ma_due_q.size() != 0) begin
         drive_idle();
      end
      repeat (3) drive_idle();
   endtask

   //////////////////////////////////////////////////
   // Directed tests
   //////////////////////////////////////////////////

   task automatic test_reset_state();
      $display("Test 1: outputs after reset");
      repeat (3) drive_idle();
      check_rsp(rsp, mem_rsp_t'{valid: 1'b0, rdata: '0}, "rsp after reset");
      check_misalign(misalign, 1'b0, "misalign after reset");
   endtask

   task automatic test_each_bank();
      $display("Test 2: write then read in every bank");
      for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
         issue_write(16'h0040 + 16'(2 * b), 16'hA500 + 16'(b));
      end
      repeat (4) drive_idle();
      for (int b = 0; b < `MEM_NUM_BANKS; b++) begin
         issue_read(16'h0040 + 16'(2 * b));
         drive_idle();
      end
      drain_responses();
   endtask

   task automatic test_back_to_back();
      $display("Test 3: back to back reads");
      // Four banks, then bank 0 at several indices
      for (int w = 0; w < 8; w++) begin
         issue_write(16'h0200 + 16'(2 * w), 16'h3C00 + 16'(w * 7));
      end
      for (int w = 0; w < 8; w++) begin
         issue_read(16'h0200 + 16'(2 * w));
      end
      issue_read(16'h0200);
      issue_read(16'h0208);
      issue_read(16'h0200);
      issue_read(16'h0208);
      drain_responses();
   endtask

   task automatic test_write_then_read();
      $display("Test 4: read right after write");
      issue_write(16'h0400, 16'h1111);
      issue_write(16'h0400, 16'h2222);
      issue_read(16'h0400);
      issue_write(16'h0406, 16'h7E57);
      issue_read(16'h0406);
      drain_responses();
   endtask

   task automatic test_misaligned();
      $display("Test 5: misaligned requests are dropped");
      issue_write(16'h0300, 16'h1234);
      issue_write(16'h0302, 16'h5678);
      drive_idle();
      issue_write(16'h0301, 16'hDEAD);
      issue_read(16'h0303);
      drive_idle();
      issue_read(16'h0300);
      issue_read(16'h0302);
      drain_responses();
   endtask

   task automatic test_random(input int num_ops);
      logic [15:0] addr;
      logic [15:0] data;
      int unsigned gap;
      $display("Test 6: %0d random aligned requests", num_ops);
      for (int i = 0; i < num_ops; i++) begin
         // Small window so reads hit written words often
         addr = 16'h0800 + 16'($urandom_range(0, 63) << 1);
         data = 16'($urandom);
         if ($urandom_range(0, 1) == 1 && model_known[addr[15:1]]) begin
            issue_read(addr);
         end else begin
            issue_write(addr, data);
         end
         if ($urandom_range(0, 3) == 0) begin
            gap = $urandom_range(1, 3);
            repeat (gap) drive_idle();
         end
      end
      drain_responses();
   endtask

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////

   initial begin
      rst = 1'b1;
      req = mem_req_t'{op: OP_IDLE, default: '0};
      void'($urandom(32'h739e_68db));
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      checking <= 1'b1;

      test_reset_state();
      test_each_bank();
      test_back_to_back();
      test_write_then_read();
      test_misaligned();
      test_random(200);

      $display("Summary: %0d response errors, %0d misalign errors",
               rsp_errors, misalign_errors);
      if (rsp_errors == 0 && misalign_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   // Watchdog on the cycle counter
   initial begin
      wait (cycle_cnt >= TIMEOUT_CYCLES);
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire
